// File: sources.f
rtl/histPkg.sv
rtl/histScanIf.sv
rtl/binMapper.sv
rtl/histBuilder.sv
rtl/peakFinder.sv
rtl/windowCalc.sv
rtl/histTop.sv
tb/histTopTb.sv

// File: Makefile
SIM      := verilator
TOP      := histTopTb
FILELIST := sources.f
SIMFLAGS := --binary --timing --assert -j 0
OBJDIR   := obj_dir
SIMBIN   := $(OBJDIR)/$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIMBIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)

# the log decides the result, a missing verdict counts as a failure
run: $(SIMBIN)
	./$(SIMBIN) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tb/histTopTb.sv
`timescale 1ns/100ps

module histTopTb;

    localparam int acqLen = 16;
    localparam int numBins = 16;
    // ready low for drain, scan and window load stays well under this
    localparam int stallLimit = 2 * (numBins + 8);
    localparam int watchdogCycles = 6 * 2 * (acqLen + numBins + 8) * 4;

    logic       clk = 1'b0;
    logic       rst;
    logic       wrEn;
    logic [9:0] roughData;
    logic       ready;
    logic       done;
    logic [3:0] peakCH;
    logic [3:0] peakFH;
    logic [9:0] tofEst;
    logic       fineEmpty;

    // samples to offer and the ones the DUT actually took
    int stimQ[$];
    int acceptedQ[$];

    // model results for the current measurement
    int expCH;
    int expFH;
    int expTof;
    int expEmpty;

    int errCount = 0;
    int errMark = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int seedInit;

    histTop #(.acqLen(acqLen)) u_dut (.*);

    // 100 ns period
    always #50 clk = ~clk;

    // hang guard sized from the test lengths
    initial begin
        #(watchdogCycles * 100);
        $display("watchdog expired after %0d cycles, run stopped", watchdogCycles);
        $display("TB FAILED");
        $finish;
    end

    task automatic reportMismatch(input string name, input int expVal, input int actVal);
        $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expVal, actVal);
        errCount++;
    endtask

    // one line per finished test
    task automatic reportTest(input string name);
        testsRun++;
        if (errCount == errMark) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s failed with %0d errors", name, errCount - errMark);
            testsFailed++;
        end
        errMark = errCount;
    endtask

    // codes step up every second sample and alternate between two bases
    task automatic fillStim(input int coarseA, input int coarseB, input int fineA,
                            input int fineB);
        stimQ.delete();
        for (int i = 0; i < acqLen; i++) begin
            stimQ.push_back(((i % 2 == 0) ? coarseA : coarseB) + i / 2);
        end
        for (int i = 0; i < acqLen; i++) begin
            stimQ.push_back(((i % 2 == 0) ? fineA : fineB) + i / 2);
        end
    endtask

    // both histograms rebuilt from the accepted samples
    task automatic computeModel;
        int cnt[numBins];
        int low;
        int best;
        int bin;
        int s;
        low = 0;
        for (int ph = 0; ph < 2; ph++) begin
            cnt = '{default: 0};
            for (int i = 0; i < acqLen; i++) begin
                s = acceptedQ[ph * acqLen + i];
                // coarse bin is code / 64 and fine bin is window offset / 4
                if (ph == 0) begin
                    bin = s / 64;
                end else begin
                    bin = (s >= low && s < low + 64) ? (s - low) / 4 : -1;
                end
                if (bin >= 0 && cnt[bin] < 255) begin
                    cnt[bin]++;
                end
            end
            // only a strictly larger count moves the peak
            best = 0;
            bin = 0;
            for (int i = 0; i < numBins; i++) begin
                if (cnt[i] > best) begin
                    best = cnt[i];
                    bin = i;
                end
            end
            if (ph == 0) begin
                expCH = bin;
                // window around the coarse peak kept inside the code range
                low = bin * 64 - 32;
                if (low < 0) begin
                    low = 0;
                end else if (low > 960) begin
                    low = 960;
                end
            end else begin
                expFH = bin;
                expEmpty = (best == 0) ? 1 : 0;
            end
        end
        // middle of the fine peak bin
        expTof = low + expFH * 4 + 2;
    endtask

    // offer samples against ready then wait for done and check
    task automatic runMeasurement(input bit randomData);
        int idx;
        int stall;
        idx = 0;
        stall = 0;
        acceptedQ.delete();
        while (acceptedQ.size() < 2 * acqLen && stall < stallLimit) begin
            @(posedge clk);
            wrEn <= 1'b1;
            // refused directed sample is offered again
            if (randomData) begin
                roughData <= 10'($urandom);
            end else begin
                roughData <= 10'(stimQ[idx]);
            end
            @(negedge clk);
            // ready now decides the next rising edge
            if (ready) begin
                acceptedQ.push_back(int'(roughData));
                idx++;
                stall = 0;
            end else begin
                stall++;
            end
        end
        // wrEn left high so these offers meet ready low
        stall = 0;
        while (!done && stall < stallLimit) begin
            @(negedge clk);
            stall++;
        end
        if (!done) begin
            $display("done never pulsed, acquisition stalled after %0d samples",
                     acceptedQ.size());
            errCount++;
        end else begin
            computeModel();
            if (int'(peakCH) != expCH) begin
                reportMismatch("peakCH", expCH, int'(peakCH));
            end
            if (int'(peakFH) != expFH) begin
                reportMismatch("peakFH", expFH, int'(peakFH));
            end
            if (int'(tofEst) != expTof) begin
                reportMismatch("tofEst", expTof, int'(tofEst));
            end
            if (int'(fineEmpty) != expEmpty) begin
                reportMismatch("fineEmpty", expEmpty, int'(fineEmpty));
            end
        end
        @(posedge clk);
        wrEn <= 1'b0;
    endtask

    task automatic checkResetState;
        if (ready !== 1'b1) begin
            reportMismatch("ready", 1, int'(ready));
        end
        if (done !== 1'b0) begin
            reportMismatch("done", 0, int'(done));
        end
        if (tofEst !== 10'd0) begin
            reportMismatch("tofEst", 0, int'(tofEst));
        end
        if (peakCH !== 4'd0) begin
            reportMismatch("peakCH", 0, int'(peakCH));
        end
        if (peakFH !== 4'd0) begin
            reportMismatch("peakFH", 0, int'(peakFH));
        end
        if (fineEmpty !== 1'b0) begin
            reportMismatch("fineEmpty", 0, int'(fineEmpty));
        end
    endtask

    // codes 326 to 333 in both phases
    task automatic singleCluster;
        fillStim(326, 326, 326, 326);
        runMeasurement(1'b0);
    endtask

    // eight hits each in coarse bins 9 and 3 with bin 9 always first
    task automatic tieRule;
        fillStim(600, 200, 180, 190);
        runMeasurement(1'b0);
        if (peakCH !== 4'd3) begin
            reportMismatch("peakCH", 3, int'(peakCH));
        end
    endtask

    // coarse peak in bin 0 then in bin 15
    task automatic clipEdges;
        fillStim(0, 0, 20, 20);
        runMeasurement(1'b0);
        fillStim(1010, 1010, 970, 970);
        runMeasurement(1'b0);
    endtask

    task automatic droppedSamples;
        // window 608 to 671 with half the fine samples below it
        fillStim(650, 650, 560, 660);
        runMeasurement(1'b0);
        // window 32 to 95 with no fine sample inside
        fillStim(100, 100, 10, 900);
        runMeasurement(1'b0);
        if (fineEmpty !== 1'b1) begin
            reportMismatch("fineEmpty", 1, int'(fineEmpty));
        end
    endtask

    // new code every cycle with wrEn high while ready drops
    task automatic randomStream;
        runMeasurement(1'b1);
    endtask

    initial begin
        seedInit = $urandom(32'h6127_70d6);
        rst = 1'b1;
        wrEn = 1'b0;
        roughData = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkResetState();
        reportTest("reset state");
        singleCluster();
        reportTest("single cluster");
        tieRule();
        reportTest("tie rule");
        clipEdges();
        reportTest("window clipping");
        droppedSamples();
        reportTest("dropped samples");
        randomStream();
        reportTest("random stream");
        $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed,
                 errCount);
        if (errCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/histTop.sv
`timescale 1ns/100ps

module histTop #(
    parameter int acqLen = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wrEn,
    input  logic [histPkg::sampleW-1:0]  roughData,
    output logic                         ready,
    output logic                         done,
    output logic [histPkg::binAddrW-1:0] peakCH,
    output logic [histPkg::binAddrW-1:0] peakFH,
    output logic [histPkg::sampleW-1:0]  tofEst,
    output logic                         fineEmpty
);

    // mapper to builder
    histPkg::phaseT               phase;
    logic [histPkg::binAddrW-1:0] mappedBin;
    logic                         inWindow;

    // window origin loop
    logic                         loadWindow;
    logic [histPkg::sampleW-1:0]  windowLow;

    // builder and peak search
    histScanIf scanBus ();

    // sample to bin address
    binMapper u_binMapper (
        .roughData (roughData),
        .phase     (phase),
        .windowLow (windowLow),
        .mappedBin (mappedBin),
        .inWindow  (inWindow)
    );

    // counters and acquisition FSM
    histBuilder #(
        .acqLen (acqLen)
    ) u_histBuilder (
        .clk        (clk),
        .rst        (rst),
        .wrEn       (wrEn),
        .mappedBin  (mappedBin),
        .inWindow   (inWindow),
        .phase      (phase),
        .ready      (ready),
        .done       (done),
        .loadWindow (loadWindow),
        .peakCH     (peakCH),
        .peakFH     (peakFH),
        .fineEmpty  (fineEmpty),
        .scan       (scanBus.builder)
    );

    // max search over the bins
    peakFinder u_peakFinder (
        .clk  (clk),
        .rst  (rst),
        .scan (scanBus.finder)
    );

    // fine window origin and time estimate
    windowCalc u_windowCalc (
        .clk        (clk),
        .rst        (rst),
        .loadWindow (loadWindow),
        .peakBin    (scanBus.peakBin),
        .peakFH     (peakFH),
        .windowLow  (windowLow),
        .tofEst     (tofEst)
    );

endmodule

// File: rtl/windowCalc.sv
`timescale 1ns/100ps

module windowCalc (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         loadWindow,
    input  logic [histPkg::binAddrW-1:0] peakBin,
    input  logic [histPkg::binAddrW-1:0] peakFH,
    output logic [histPkg::sampleW-1:0]  windowLow,
    output logic [histPkg::sampleW-1:0]  tofEst
);

    localparam int sampleW = histPkg::sampleW;
    localparam int binAddrW = histPkg::binAddrW;
    localparam int fineShift = histPkg::fineShift;

    // window shifted back by half its width
    localparam int halfSpan = histPkg::windowSpan / 2;

    // highest origin that keeps the window inside the code range
    localparam int lowMax = (1 << sampleW) - histPkg::windowSpan;

    // middle of a fine bin
    localparam logic [sampleW-1:0] fineHalf = sampleW'(1 << (fineShift - 1));

    int                 rawLow;
    logic [sampleW-1:0] clippedLow;
    logic [sampleW-1:0] fineOffset;
    logic               windowLoaded;

    // origin from the coarse peak, clipped on both ends
    always_comb begin
        rawLow = int'(peakBin) * (1 << histPkg::coarseShift) - halfSpan;
        if (rawLow < 0) begin
            clippedLow = '0;
        end else if (rawLow > lowMax) begin
            clippedLow = sampleW'(lowMax);
        end else begin
            clippedLow = rawLow[sampleW-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            windowLow <= '0;
            windowLoaded <= 1'b0;
        end else if (loadWindow) begin
            windowLow <= clippedLow;
            windowLoaded <= 1'b1;
        end
    end

    // fine bin start relative to the window
    assign fineOffset = {{(sampleW - binAddrW - fineShift){1'b0}}, peakFH, {fineShift{1'b0}}};

    // no estimate until a first window exists
    assign tofEst = windowLoaded ? (windowLow + fineOffset + fineHalf) : '0;

endmodule

// File: rtl/peakFinder.sv
`timescale 1ns/100ps

module peakFinder (
    input  logic      clk,
    input  logic      rst,
    histScanIf.finder scan
);

    localparam int numBins = histPkg::numBins;
    localparam int binAddrW = histPkg::binAddrW;
    localparam int countW = histPkg::countW;

    logic                scanActive;
    logic [binAddrW-1:0] addr;

    // running best so far
    logic [countW-1:0]   runMax;
    logic [binAddrW-1:0] runBin;

    logic                better;
    logic                lastAddr;
    logic [countW-1:0]   nextMax;
    logic [binAddrW-1:0] nextBin;

    assign scan.binAddr = addr;

    // only a strictly larger count wins so a tie keeps the earlier bin
    assign better = (scan.binCount > runMax);
    assign lastAddr = (addr == binAddrW'(numBins - 1));
    assign nextMax = better ? scan.binCount : runMax;
    assign nextBin = better ? addr : runBin;

    // scan sequencing
    always_ff @(posedge clk) begin
        if (rst) begin
            scanActive <= 1'b0;
            addr <= '0;
            scan.scanDone <= 1'b0;
        end else begin
            scan.scanDone <= 1'b0;
            if (scan.scanStart) begin
                scanActive <= 1'b1;
                addr <= '0;
            end else if (scanActive) begin
                if (lastAddr) begin
                    scanActive <= 1'b0;
                    addr <= '0;
                    scan.scanDone <= 1'b1;
                end else begin
                    addr <= addr + 1'b1;
                end
            end
        end
    end

    // running maximum and held result
    always_ff @(posedge clk) begin
        if (scan.scanStart) begin
            // empty histogram falls back to bin 0
            runMax <= '0;
            runBin <= '0;
        end else if (scanActive) begin
            runMax <= nextMax;
            runBin <= nextBin;
            if (lastAddr) begin
                scan.peakBin <= nextBin;
                scan.peakCount <= nextMax;
            end
        end
    end

    // address stays in the bin range with no restart cutting a scan short
    assert property (@(posedge clk) disable iff (rst)
        scanActive |-> (!scan.scanStart && (int'(scan.binAddr) < numBins)));

endmodule

// File: rtl/histBuilder.sv
`timescale 1ns/100ps

module histBuilder #(
    parameter int acqLen = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wrEn,
    input  logic [histPkg::binAddrW-1:0] mappedBin,
    input  logic                         inWindow,
    output histPkg::phaseT               phase,
    output logic                         ready,
    output logic                         done,
    output logic                         loadWindow,
    output logic [histPkg::binAddrW-1:0] peakCH,
    output logic [histPkg::binAddrW-1:0] peakFH,
    output logic                         fineEmpty,
    histScanIf.builder                   scan
);

    localparam int numBins = histPkg::numBins;
    localparam int countW = histPkg::countW;
    localparam int sampCntW = $clog2(acqLen + 1);

    // one saturating counter per bin packed for whole compares
    logic [numBins-1:0][countW-1:0] binCnt;

    // samples accepted in the current phase
    logic [sampCntW-1:0] sampleCnt;

    histPkg::acqStateT state;

    logic accept;
    logic lastSample;
    logic clearCnt;
    logic binFull;

    // sample taken on wrEn and ready together
    assign accept = wrEn && ready;
    assign lastSample = (sampleCnt == sampCntW'(acqLen - 1));

    // counters wiped on the way back into acquisition
    assign clearCnt = (state == histPkg::ST_WINDOW) || (state == histPkg::ST_REPORT);

    // saturation at all ones
    assign binFull = &binCnt[mappedBin];

    // status decoded straight from the state
    assign ready = (state == histPkg::ST_ACQ);
    assign done = (state == histPkg::ST_REPORT);
    assign loadWindow = (state == histPkg::ST_WINDOW);

    // drain cycle kicks off the scan
    assign scan.scanStart = (state == histPkg::ST_DRAIN);

    // count read back for the address under scan
    assign scan.binCount = binCnt[scan.binAddr];

    // bin counter array
    always_ff @(posedge clk) begin
        if (rst) begin
            binCnt <= '0;
        end else if (clearCnt) begin
            binCnt <= '0;
        end else if (accept && inWindow && !binFull) begin
            binCnt[mappedBin] <= binCnt[mappedBin] + 1'b1;
        end
    end

    // accepted sample counter that also counts out-of-window samples
    always_ff @(posedge clk) begin
        if (rst) begin
            sampleCnt <= '0;
        end else if (clearCnt) begin
            sampleCnt <= '0;
        end else if (accept) begin
            sampleCnt <= sampleCnt + 1'b1;
        end
    end

    // acquisition controller
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= histPkg::ST_ACQ;
            phase <= histPkg::PH_COARSE;
            peakCH <= '0;
            peakFH <= '0;
            fineEmpty <= 1'b0;
        end else begin
            case (state)
                histPkg::ST_ACQ: begin
                    if (accept && lastSample) begin
                        state <= histPkg::ST_DRAIN;
                    end
                end
                histPkg::ST_DRAIN: begin
                    state <= histPkg::ST_SCAN;
                end
                histPkg::ST_SCAN: begin
                    if (scan.scanDone) begin
                        if (phase == histPkg::PH_COARSE) begin
                            peakCH <= scan.peakBin;
                            state <= histPkg::ST_WINDOW;
                        end else begin
                            // finder already lands on bin 0 for an empty histogram
                            peakFH <= scan.peakBin;
                            fineEmpty <= (scan.peakCount == '0);
                            state <= histPkg::ST_REPORT;
                        end
                    end
                end
                histPkg::ST_WINDOW: begin
                    phase <= histPkg::PH_FINE;
                    state <= histPkg::ST_ACQ;
                end
                histPkg::ST_REPORT: begin
                    phase <= histPkg::PH_COARSE;
                    state <= histPkg::ST_ACQ;
                end
                default: begin
                    state <= histPkg::ST_ACQ;
                end
            endcase
        end
    end

    // with ready low only a clear may touch the bins
    assert property (@(posedge clk) disable iff (rst)
        (!ready && !clearCnt) |=> $stable(binCnt));

    // done is a single-cycle pulse
    assert property (@(posedge clk) disable iff (rst)
        done |=> !done);

endmodule

// File: rtl/binMapper.sv
`timescale 1ns/100ps

module binMapper (
    input  logic [histPkg::sampleW-1:0]  roughData,
    input  histPkg::phaseT               phase,
    input  logic [histPkg::sampleW-1:0]  windowLow,
    output logic [histPkg::binAddrW-1:0] mappedBin,
    output logic                         inWindow
);

    localparam int sampleW = histPkg::sampleW;
    localparam int binAddrW = histPkg::binAddrW;

    // one extra bit so a sample below the origin shows up as a borrow
    logic [sampleW:0] fineOffset;
    logic             belowWindow;
    logic             aboveWindow;

    assign fineOffset = {1'b0, roughData} - {1'b0, windowLow};

    // borrow out means the sample sits left of the window
    assign belowWindow = fineOffset[sampleW];

    // offset past the last fine bin
    assign aboveWindow = (fineOffset[sampleW-1:0] >= sampleW'(histPkg::windowSpan));

    always_comb begin
        if (phase == histPkg::PH_COARSE) begin
            // coarse bin is just the top bits of the code
            mappedBin = roughData[histPkg::coarseShift +: binAddrW];
            inWindow = 1'b1;
        end else begin
            // fine bin from the offset into the window
            mappedBin = fineOffset[histPkg::fineShift +: binAddrW];
            inWindow = !belowWindow && !aboveWindow;
        end
    end

endmodule

// File: rtl/histScanIf.sv
`timescale 1ns/100ps

interface histScanIf;

    // start of a bin scan, one cycle wide
    logic scanStart;

    // bin being read by the peak search
    logic [histPkg::binAddrW-1:0] binAddr;

    // count held at binAddr
    logic [histPkg::countW-1:0] binCount;

    // end of scan, one cycle wide, result valid from here on
    logic scanDone;
    logic [histPkg::binAddrW-1:0] peakBin;
    logic [histPkg::countW-1:0] peakCount;

    // histogram side, owns the counters
    modport builder (
        output scanStart,
        output binCount,
        input  binAddr,
        input  scanDone,
        input  peakBin,
        input  peakCount
    );

    // peak search side
    modport finder (
        input  scanStart,
        input  binCount,
        output binAddr,
        output scanDone,
        output peakBin,
        output peakCount
    );

endinterface

// File: rtl/histPkg.sv
package histPkg;

    // raw timing sample width
    localparam int sampleW = 10;

    // bins per histogram and matching address width
    localparam int numBins = 16;
    localparam int binAddrW = 4;

    // bin counter width, counters stop at all ones
    localparam int countW = 8;

    // coarse bins are 64 codes wide
    localparam int coarseShift = 6;

    // fine bins are 4 codes wide
    localparam int fineShift = 2;

    // fine window covers 16 fine bins
    localparam int windowSpan = 64;

    // which histogram is being filled
    typedef enum logic {
        PH_COARSE,
        PH_FINE
    } phaseT;

    // acquisition controller states
    typedef enum logic [2:0] {
        // samples accepted, ready high
        ST_ACQ,
        // one idle cycle after the last accepted sample
        ST_DRAIN,
        // peak search running over all bins
        ST_SCAN,
        // window origin load, counters cleared for fine phase
        ST_WINDOW,
        // done pulse, counters cleared for next measurement
        ST_REPORT
    } acqStateT;

endpackage
